//--- src/core_pkg.sv
package core_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Machine CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC  = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC   = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE = 12'h342;

    // Environment call from M-mode
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_CSRRW   = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // SYSTEM words matched in full
    localparam logic [XLEN-1:0] INST_ECALL = 32'h0000_0073;
    localparam logic [XLEN-1:0] INST_MRET  = 32'h3020_0073;

    // Decoded operation
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_CSRRW,
        OP_ECALL,
        OP_MRET
    } op_e;

endpackage

//--- src/pcu.sv
module pcu import core_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [XLEN-1:0] npc_i,
    output logic [XLEN-1:0] pc_o
);

    // One instruction retires per cycle, so pc follows npc every edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o <= RESET_PC;
        end else begin
            pc_o <= npc_i;
        end
    end

endmodule

//--- src/idu.sv
module idu import core_pkg::*; (
    input  logic [XLEN-1:0]       inst_i,
    output op_e                   op_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  reg_wen_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_j_type;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rd_o       = inst_i[11:7];
    assign rs1_o      = inst_i[19:15];
    assign rs2_o      = inst_i[24:20];
    assign csr_addr_o = inst_i[31:20];

    // Sign-extended immediates for each format
    assign imm_i_type = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        op_o = OP_NOP;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD_SUB) begin
                    op_o = OP_ADDI;
                end
            end
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: op_o = OP_ADD;
                        F3_SLT:     op_o = OP_SLT;
                        F3_XOR:     op_o = OP_XOR;
                        F3_OR:      op_o = OP_OR;
                        F3_AND:     op_o = OP_AND;
                        default:    op_o = OP_NOP;
                    endcase
                end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                    op_o = OP_SUB;
                end
            end
            OPC_LUI: op_o = OP_LUI;
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    op_o = OP_BEQ;
                end else if (funct3 == F3_BNE) begin
                    op_o = OP_BNE;
                end
            end
            OPC_JAL: op_o = OP_JAL;
            OPC_SYSTEM: begin
                // ECALL and MRET share funct3 zero, so match the whole word
                if (inst_i == INST_ECALL) begin
                    op_o = OP_ECALL;
                end else if (inst_i == INST_MRET) begin
                    op_o = OP_MRET;
                end else if (funct3 == F3_CSRRW) begin
                    op_o = OP_CSRRW;
                end
            end
            default: op_o = OP_NOP;
        endcase
    end

    always_comb begin
        case (op_o)
            OP_LUI:         imm_o = imm_u_type;
            OP_BEQ, OP_BNE: imm_o = imm_b_type;
            OP_JAL:         imm_o = imm_j_type;
            default:        imm_o = imm_i_type;
        endcase
    end

    always_comb begin
        case (op_o)
            OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
            OP_LUI, OP_JAL, OP_CSRRW: reg_wen_o = 1'b1;
            default:                  reg_wen_o = 1'b0;
        endcase
    end

endmodule

//--- src/regs.sv
module regs import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  wen_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       src1_o,
    output logic [XLEN-1:0]       src2_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] gpr [NUM_REGS];

    // x0 is never written, so it keeps the zero loaded at reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                gpr[i] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin
            gpr[rd_i] <= wdata_i;
        end
    end

    // Reads see the state before this cycle's write
    assign src1_o = gpr[rs1_i];
    assign src2_o = gpr[rs2_i];

endmodule

//--- src/csr.sv
module csr import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  op_e                   op_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic [XLEN-1:0]       rdata_o,
    output logic [XLEN-1:0]       mtvec_o,
    output logic [XLEN-1:0]       mepc_o,
    output logic [XLEN-1:0]       mcause_o
);

    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtvec_q  <= '0;
            mepc_q   <= '0;
            mcause_q <= '0;
        end else begin
            case (op_i)
                OP_CSRRW: begin
                    case (csr_addr_i)
                        CSR_MTVEC:  mtvec_q  <= wdata_i;
                        CSR_MEPC:   mepc_q   <= wdata_i;
                        CSR_MCAUSE: mcause_q <= wdata_i;
                        default:    ;
                    endcase
                end
                // Trap entry records where it came from and why
                OP_ECALL: begin
                    mepc_q   <= pc_i;
                    mcause_q <= CAUSE_ECALL_M;
                end
                default: ;
            endcase
        end
    end

    // Old value for CSRRW, zero outside the implemented set
    always_comb begin
        case (csr_addr_i)
            CSR_MTVEC:  rdata_o = mtvec_q;
            CSR_MEPC:   rdata_o = mepc_q;
            CSR_MCAUSE: rdata_o = mcause_q;
            default:    rdata_o = '0;
        endcase
    end

    assign mtvec_o  = mtvec_q;
    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule

//--- src/exu.sv
module exu import core_pkg::*; (
    input  op_e             op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] csr_rdata_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    output logic [XLEN-1:0] res_o,
    output logic [XLEN-1:0] npc_o
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_target;
    logic            src_eq;
    logic            src_lt;

    assign pc_plus4  = pc_i + XLEN'(4);
    assign pc_target = pc_i + imm_i;
    assign src_eq    = (src1_i == src2_i);
    assign src_lt    = ($signed(src1_i) < $signed(src2_i));

    // Write-back value
    always_comb begin
        case (op_i)
            OP_ADDI:  res_o = src1_i + imm_i;
            OP_ADD:   res_o = src1_i + src2_i;
            OP_SUB:   res_o = src1_i - src2_i;
            OP_AND:   res_o = src1_i & src2_i;
            OP_OR:    res_o = src1_i | src2_i;
            OP_XOR:   res_o = src1_i ^ src2_i;
            OP_SLT:   res_o = {{(XLEN-1){1'b0}}, src_lt};
            OP_LUI:   res_o = imm_i;
            // Link address
            OP_JAL:   res_o = pc_plus4;
            OP_CSRRW: res_o = csr_rdata_i;
            default:  res_o = '0;
        endcase
    end

    // Next pc
    always_comb begin
        case (op_i)
            OP_BEQ:   npc_o = src_eq ? pc_target : pc_plus4;
            OP_BNE:   npc_o = src_eq ? pc_plus4 : pc_target;
            OP_JAL:   npc_o = pc_target;
            OP_ECALL: npc_o = mtvec_i;
            OP_MRET:  npc_o = mepc_i;
            default:  npc_o = pc_plus4;
        endcase
    end

endmodule

//--- src/core_top.sv
module core_top import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       inst_i,
    output logic [XLEN-1:0]       pc_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       mepc_o,
    output logic [XLEN-1:0]       mcause_o
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       npc;
    op_e                   op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  reg_wen;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
    logic [XLEN-1:0]       csr_rdata;
    logic [XLEN-1:0]       mtvec;
    logic [XLEN-1:0]       mepc;
    logic [XLEN-1:0]       res;

    pcu pcu0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .npc_i   (npc),
        .pc_o    (pc)
    );

    idu idu0 (
        .inst_i     (inst_i),
        .op_o       (op),
        .rd_o       (rd),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .imm_o      (imm),
        .reg_wen_o  (reg_wen),
        .csr_addr_o (csr_addr)
    );

    regs regs0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wen_i   (reg_wen),
        .rd_i    (rd),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .wdata_i (res),
        .src1_o  (src1),
        .src2_o  (src2)
    );

    // CSRRW writes the rs1 value
    csr csr0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .op_i       (op),
        .csr_addr_i (csr_addr),
        .wdata_i    (src1),
        .pc_i       (pc),
        .rdata_o    (csr_rdata),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc),
        .mcause_o   (mcause_o)
    );

    exu exu0 (
        .op_i        (op),
        .pc_i        (pc),
        .src1_i      (src1),
        .src2_i      (src2),
        .imm_i       (imm),
        .csr_rdata_i (csr_rdata),
        .mtvec_i     (mtvec),
        .mepc_i      (mepc),
        .res_o       (res),
        .npc_o       (npc)
    );

    assign pc_o = pc;

    // Write-back seen by the environment, x0 targets never count
    // Nothing retires while in reset
    assign wb_en_o   = reg_wen && (rd != '0) && !reset_i;
    assign wb_rd_o   = rd;
    assign wb_data_o = res;
    assign mepc_o    = mepc;

endmodule

//--- dv/core_tb.sv
module core_tb import core_pkg::*; ();

    logic                  clk_i;
    logic                  reset_i;
    logic [XLEN-1:0]       inst_i;
    logic [XLEN-1:0]       pc_o;
    logic                  wb_en_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic [XLEN-1:0]       mepc_o;
    logic [XLEN-1:0]       mcause_o;

    // Program memory, one word per entry starting at RESET_PC
    logic [XLEN-1:0] prog [$];
    logic [XLEN-1:0] end_pc;

    // Reference model state
    logic [XLEN-1:0]       model_x [32];
    logic [XLEN-1:0]       model_pc;
    logic [XLEN-1:0]       model_mtvec;
    logic [XLEN-1:0]       model_mepc;
    logic [XLEN-1:0]       model_mcause;
    logic                  exp_wen;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_data;

    int checks;
    int err_pc;
    int err_wb;
    int err_csr;
    int timed_out;

    core_top dut0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .inst_i    (inst_i),
        .pc_o      (pc_o),
        .wb_en_o   (wb_en_o),
        .wb_rd_o   (wb_rd_o),
        .wb_data_o (wb_data_o),
        .mepc_o    (mepc_o),
        .mcause_o  (mcause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [XLEN-1:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [XLEN-1:0] btype_word(input logic [12:0] off, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [XLEN-1:0] jtype_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Past the end of the program the core sees ADDI x0, x0, 0
    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] == 2'b00 && idx < prog.size()) begin
            return prog[idx];
        end else begin
            return 32'h0000_0013;
        end
    endfunction

    // Executes one instruction on the model and sets the expected write-back
    function automatic void model_step(input logic [XLEN-1:0] inst);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] next;
        logic [XLEN-1:0] data;
        logic            wen;
        opc   = inst[6:0];
        f3    = inst[14:12];
        f7    = inst[31:25];
        rd    = inst[11:7];
        a     = model_x[inst[19:15]];
        b     = model_x[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        next  = model_pc + 32'd4;
        data  = '0;
        wen   = 1'b0;
        case (opc)
            7'b0010011: begin
                wen  = (f3 == 3'b000);
                data = a + imm_i;
            end
            7'b0110011: begin
                wen = 1'b1;
                if (f7 == 7'b0100000 && f3 == 3'b000) data = a - b;
                else if (f7 != 7'b0000000) wen = 1'b0;
                else if (f3 == 3'b000) data = a + b;
                else if (f3 == 3'b010) data = XLEN'($signed(a) < $signed(b));
                else if (f3 == 3'b100) data = a ^ b;
                else if (f3 == 3'b110) data = a | b;
                else if (f3 == 3'b111) data = a & b;
                else wen = 1'b0;
            end
            7'b0110111: begin
                wen  = 1'b1;
                data = {inst[31:12], 12'b0};
            end
            7'b1100011: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    next = model_pc + imm_b;
                end
            end
            7'b1101111: begin
                wen  = 1'b1;
                data = model_pc + 32'd4;
                next = model_pc + imm_j;
            end
            7'b1110011: begin
                if (inst == 32'h0000_0073) begin
                    model_mepc   = model_pc;
                    model_mcause = CAUSE_ECALL_M;
                    next         = model_mtvec;
                end else if (inst == 32'h3020_0073) begin
                    next = model_mepc;
                end else if (f3 == 3'b001) begin
                    wen = 1'b1;
                    // Read the old value first, then swap in rs1
                    case (inst[31:20])
                        CSR_MTVEC: begin
                            data        = model_mtvec;
                            model_mtvec = a;
                        end
                        CSR_MEPC: begin
                            data       = model_mepc;
                            model_mepc = a;
                        end
                        CSR_MCAUSE: begin
                            data         = model_mcause;
                            model_mcause = a;
                        end
                        default: data = '0;
                    endcase
                end
            end
            default: ;
        endcase
        exp_wen  = wen && (rd != 5'd0);
        exp_rd   = rd;
        exp_data = data;
        if (exp_wen) model_x[rd] = data;
        model_pc = next;
    endfunction

    task automatic check_pc(input logic [XLEN-1:0] exp_pc);
        checks++;
        if (pc_o !== exp_pc) begin
            err_pc++;
            $display("ERROR %0t: pc_o is %h, expected %h", $time, pc_o, exp_pc);
        end
    endtask

    task automatic check_wb(input logic en, input logic [REG_ADDR_W-1:0] rd,
                            input logic [XLEN-1:0] data);
        checks++;
        if (wb_en_o !== en) begin
            err_wb++;
            $display("ERROR %0t: wb_en_o is %b, expected %b", $time, wb_en_o, en);
        end else if (en && (wb_rd_o !== rd || wb_data_o !== data)) begin
            err_wb++;
            $display("ERROR %0t: write-back x%0d = %h, expected x%0d = %h",
                     $time, wb_rd_o, wb_data_o, rd, data);
        end
    endtask

    task automatic check_csr(input logic [XLEN-1:0] mepc, input logic [XLEN-1:0] mcause);
        checks++;
        if (mepc_o !== mepc || mcause_o !== mcause) begin
            err_csr++;
            $display("ERROR %0t: mepc/mcause are %h/%h, expected %h/%h",
                     $time, mepc_o, mcause_o, mepc, mcause);
        end
    endtask

    // Compare on the falling edge, where inputs and outputs are settled
    initial begin
        // First compare comes after the first reset edge
        @(posedge clk_i);
        forever begin
            @(negedge clk_i);
            if (reset_i) begin
                check_pc(RESET_PC);
                check_wb(1'b0, '0, '0);
            end else begin
                check_pc(model_pc);
                check_csr(model_mepc, model_mcause);
                model_step(inst_i);
                check_wb(exp_wen, exp_rd, exp_data);
            end
        end
    end

    initial begin
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          kind;
        int          cycles;
        logic [2:0]  f3_list [6];
        void'($urandom(52));
        checks    = 0;
        err_pc    = 0;
        err_wb    = 0;
        err_csr   = 0;
        timed_out = 0;
        reset_i   = 1'b1;
        // A writing instruction held through reset
        inst_i    = itype_word(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);
        f3_list   = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};

        // Directed part: ALU, x0, branches, JAL, CSRRW, ECALL and MRET
        prog.push_back(itype_word(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
        prog.push_back(itype_word(12'hffd, 5'd0, 3'b000, 5'd2, 7'b0010011));
        prog.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        prog.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        prog.push_back(rtype_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        prog.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd9));
        prog.push_back({20'habcde, 5'd10, 7'b0110111});
        prog.push_back(itype_word(12'd7, 5'd1, 3'b000, 5'd0, 7'b0010011));
        prog.push_back(rtype_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd11));
        prog.push_back(btype_word(13'd8, 5'd1, 5'd1, 3'b000));
        prog.push_back(itype_word(12'd99, 5'd0, 3'b000, 5'd12, 7'b0010011));
        prog.push_back(btype_word(13'd8, 5'd2, 5'd1, 3'b000));
        prog.push_back(btype_word(13'd8, 5'd2, 5'd1, 3'b001));
        prog.push_back(itype_word(12'd77, 5'd0, 3'b000, 5'd12, 7'b0010011));
        prog.push_back(btype_word(13'd8, 5'd1, 5'd1, 3'b001));
        prog.push_back(jtype_word(21'd8, 5'd13));
        prog.push_back(itype_word(12'd55, 5'd0, 3'b000, 5'd12, 7'b0010011));
        prog.push_back(itype_word(12'd100, 5'd0, 3'b000, 5'd14, 7'b0010011));
        prog.push_back(itype_word(CSR_MTVEC, 5'd14, 3'b001, 5'd15, 7'b1110011));
        prog.push_back(itype_word(CSR_MTVEC, 5'd14, 3'b001, 5'd16, 7'b1110011));
        prog.push_back(32'h0000_0073);
        prog.push_back(jtype_word(21'd20, 5'd0));
        // Trap handler at 100 moves mepc past the ECALL and returns
        prog.push_back(itype_word(CSR_MEPC, 5'd0, 3'b001, 5'd17, 7'b1110011));
        prog.push_back(itype_word(12'd4, 5'd17, 3'b000, 5'd17, 7'b0010011));
        prog.push_back(itype_word(CSR_MEPC, 5'd17, 3'b001, 5'd0, 7'b1110011));
        prog.push_back(32'h3020_0073);

        // Random ALU part, x0 included as a target
        for (int i = 0; i < 300; i++) begin
            kind = int'($urandom_range(0, 7));
            rd   = 5'($urandom_range(0, 31));
            rs1  = 5'($urandom_range(0, 31));
            rs2  = 5'($urandom_range(0, 31));
            if (kind == 7) begin
                prog.push_back({20'($urandom), rd, 7'b0110111});
            end else if (kind == 6) begin
                prog.push_back(itype_word(12'($urandom), rs1, 3'b000, rd, 7'b0010011));
            end else begin
                prog.push_back(rtype_word(kind == 1 ? 7'h20 : 7'h00, rs2, rs1,
                                          f3_list[kind], rd));
            end
        end
        end_pc = XLEN'(prog.size() * 4);
        prog.push_back(jtype_word(21'd0, 5'd0));

        model_pc     = RESET_PC;
        model_mtvec  = '0;
        model_mepc   = '0;
        model_mcause = '0;
        for (int i = 0; i < 32; i++) begin
            model_x[i] = '0;
        end

        repeat (2) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        cycles  = 0;
        while (pc_o !== end_pc && cycles < 2000) begin
            inst_i = fetch_word(pc_o);
            @(posedge clk_i);
            #2;
            cycles++;
        end
        if (pc_o !== end_pc) begin
            timed_out = 1;
            $display("Timeout: the program end was not reached within %0d cycles", cycles);
        end
        // Let the closing self-jump retire too
        inst_i = fetch_word(pc_o);
        @(posedge clk_i);
        #2;

        $display("Checks %0d, errors: pc %0d, write-back %0d, csr %0d, timeout %0d",
                 checks, err_pc, err_wb, err_csr, timed_out);
        if (err_pc + err_wb + err_csr + timed_out == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rv_core.f
src/core_pkg.sv
src/pcu.sv
src/idu.sv
src/regs.sv
src/csr.sv
src/exu.sv
src/core_top.sv
dv/core_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module core_top -f rv_core.f

sim:
	verilator --binary --timing -j 0 --top-module core_tb -f rv_core.f -o vsim
	@out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir
